//--- Makefile
# Verilator build for the core testbench

VERILATOR  ?= verilator
TOP        := tb_core
FILELIST   := sim.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- core_ex_stage.sv
////////////////////////////////////////////////////////////
// Execute stage with write-back register
// ALU, store request on the data bus, register file write
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module core_ex_stage import core_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  id_valid_i,
  input  id_ex_t                id_ex_i,
  input  logic                  data_gnt_i,
  output logic                  ex_ready_o,
  output logic                  data_req_o,
  output logic [XLEN-1:0]       data_addr_o,
  output logic [3:0]            data_be_o,
  output logic [XLEN-1:0]       data_wdata_o,
  output logic                  ex_fwd_we_o,
  output logic [REG_ADDR_W-1:0] ex_fwd_rd_o,
  output logic [XLEN-1:0]       ex_fwd_data_o,
  output logic                  wb_fwd_we_o,
  output logic [REG_ADDR_W-1:0] wb_fwd_rd_o,
  output logic [XLEN-1:0]       wb_fwd_data_o,
  rf_if.writer                  rf
);

  logic [XLEN-1:0]       alu_result;
  logic                  retire;
  logic                  wb_we_q;
  logic [REG_ADDR_W-1:0] wb_rd_q;
  logic [XLEN-1:0]       wb_data_q;

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (id_ex_i.alu_op)
      ALU_ADD:    alu_result = id_ex_i.op_a + id_ex_i.op_b;
      ALU_SUB:    alu_result = id_ex_i.op_a - id_ex_i.op_b;
      ALU_AND:    alu_result = id_ex_i.op_a & id_ex_i.op_b;
      ALU_OR:     alu_result = id_ex_i.op_a | id_ex_i.op_b;
      ALU_XOR:    alu_result = id_ex_i.op_a ^ id_ex_i.op_b;
      // Shift amount from the low five bits
      ALU_SLL:    alu_result = id_ex_i.op_a << id_ex_i.op_b[4:0];
      ALU_SRL:    alu_result = id_ex_i.op_a >> id_ex_i.op_b[4:0];
      ALU_PASS_B: alu_result = id_ex_i.op_b;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Store request
  ////////////////////////////////////////////////////////////

  // Held straight from the ID/EX register, so stable until grant
  assign data_req_o  = id_valid_i && id_ex_i.store;
  // Word address, byte lanes picked by the enables
  assign data_addr_o = {alu_result[XLEN-1:2], 2'b00};
  assign data_be_o   = id_ex_i.store_byte ? (4'b0001 << alu_result[1:0]) : 4'b1111;
  // SB replicates the low byte on every lane
  assign data_wdata_o = id_ex_i.store_byte ? {4{id_ex_i.store_data[7:0]}}
                                           : id_ex_i.store_data;

  // Store done at grant, ALU ops always take one cycle
  assign ex_ready_o = !data_req_o || data_gnt_i;
  assign retire     = id_valid_i && ex_ready_o;

  // Result of the instruction in EX, for ID
  assign ex_fwd_we_o   = id_valid_i && id_ex_i.rf_we;
  assign ex_fwd_rd_o   = id_ex_i.rd;
  assign ex_fwd_data_o = alu_result;

  ////////////////////////////////////////////////////////////
  // WB register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wb_we_q <= 1'b0;
    end else begin
      wb_we_q <= retire && id_ex_i.rf_we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (retire) begin
      wb_rd_q   <= id_ex_i.rd;
      wb_data_q <= alu_result;
    end
  end

  // Register file picks it up at the next edge
  assign rf.we    = wb_we_q;
  assign rf.waddr = wb_rd_q;
  assign rf.wdata = wb_data_q;

  // Same value forwarded while the write is pending
  assign wb_fwd_we_o   = wb_we_q;
  assign wb_fwd_rd_o   = wb_rd_q;
  assign wb_fwd_data_o = wb_data_q;

  // Waiting store keeps its request and address
  a_store_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o)
  );

endmodule

`default_nettype wire

//--- core_id_stage.sv
////////////////////////////////////////////////////////////
// Decode stage
// Decoder, immediates, forwarding and the ID/EX register
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module core_id_stage import core_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  if_valid_i,
  input  if_id_t                if_id_i,
  input  logic                  ex_ready_i,
  input  logic                  ex_fwd_we_i,
  input  logic [REG_ADDR_W-1:0] ex_fwd_rd_i,
  input  logic [XLEN-1:0]       ex_fwd_data_i,
  input  logic                  wb_fwd_we_i,
  input  logic [REG_ADDR_W-1:0] wb_fwd_rd_i,
  input  logic [XLEN-1:0]       wb_fwd_data_i,
  rf_if.reader                  rf,
  output logic                  id_ready_o,
  output logic                  id_valid_o,
  output id_ex_t                id_ex_o
);

  logic [XLEN-1:0]       instr;
  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       imm_i;
  logic [XLEN-1:0]       imm_s;
  logic [XLEN-1:0]       imm_u;
  logic [XLEN-1:0]       rs1_val;
  logic [XLEN-1:0]       rs2_val;
  logic                  accept;
  logic                  id_valid_q;
  id_ex_t                id_ex_d;
  id_ex_t                id_ex_q;

  // Instruction fields
  assign instr  = if_id_i.instr;
  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];

  // I, S and U immediates, sign extended where needed
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'h000};

  ////////////////////////////////////////////////////////////
  // Operand forwarding
  ////////////////////////////////////////////////////////////

  assign rf.raddr_a = rs1;
  assign rf.raddr_b = rs2;

  // EX result first, then WB register, then register file
  // x0 never matches, writes to it are never flagged
  function automatic logic [XLEN-1:0] fwd_sel(
    input logic [REG_ADDR_W-1:0] addr,
    input logic [XLEN-1:0]       rf_val
  );
    if (ex_fwd_we_i && (ex_fwd_rd_i == addr)) begin
      return ex_fwd_data_i;
    end else if (wb_fwd_we_i && (wb_fwd_rd_i == addr)) begin
      return wb_fwd_data_i;
    end
    return rf_val;
  endfunction

  always_comb begin
    rs1_val = fwd_sel(rs1, rf.rdata_a);
    rs2_val = fwd_sel(rs2, rf.rdata_b);
  end

  ////////////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Defaults give a no-op
    id_ex_d            = '0;
    id_ex_d.alu_op     = ALU_ADD;
    id_ex_d.op_a       = rs1_val;
    id_ex_d.op_b       = rs2_val;
    id_ex_d.store_data = rs2_val;
    id_ex_d.rd         = rd;
    case (opcode)
      OPC_OP: begin
        // SUB is the only alternate encoding kept
        id_ex_d.rf_we = (funct7 == F7_BASE) || ((funct7 == F7_ALT) && (funct3 == F3_ADD));
        case (funct3)
          F3_ADD:  id_ex_d.alu_op = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
          F3_SLL:  id_ex_d.alu_op = ALU_SLL;
          F3_XOR:  id_ex_d.alu_op = ALU_XOR;
          F3_SRL:  id_ex_d.alu_op = ALU_SRL;
          F3_OR:   id_ex_d.alu_op = ALU_OR;
          F3_AND:  id_ex_d.alu_op = ALU_AND;
          default: id_ex_d.rf_we  = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        id_ex_d.op_b  = imm_i;
        id_ex_d.rf_we = 1'b1;
        case (funct3)
          F3_ADD:  id_ex_d.alu_op = ALU_ADD;
          F3_XOR:  id_ex_d.alu_op = ALU_XOR;
          F3_OR:   id_ex_d.alu_op = ALU_OR;
          F3_AND:  id_ex_d.alu_op = ALU_AND;
          // Shifts by immediate and compares retire as no-ops
          default: id_ex_d.rf_we  = 1'b0;
        endcase
      end
      OPC_LUI: begin
        id_ex_d.alu_op = ALU_PASS_B;
        id_ex_d.op_b   = imm_u;
        id_ex_d.rf_we  = 1'b1;
      end
      OPC_STORE: begin
        // Address is rs1 + S immediate through the adder
        id_ex_d.op_b       = imm_s;
        id_ex_d.store      = (funct3 == F3_SW) || (funct3 == F3_SB);
        id_ex_d.store_byte = (funct3 == F3_SB);
      end
      default: ;
    endcase
    if (rd == '0) begin
      id_ex_d.rf_we = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////////////////////////

  assign id_ready_o = !id_valid_q || ex_ready_i;
  assign accept     = if_valid_i && id_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      id_valid_q <= 1'b0;
    end else if (accept) begin
      id_valid_q <= 1'b1;
    end else if (ex_ready_i) begin
      id_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_ex_q <= id_ex_d;
    end
  end

  assign id_valid_o = id_valid_q;
  assign id_ex_o    = id_ex_q;

  // IF must hold its instruction while ID is stalled
  a_payload_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    if_valid_i && !id_ready_o |=> if_valid_i && $stable(if_id_i)
  );

endmodule

`default_nettype wire

//--- core_if_stage.sv
////////////////////////////////////////////////////////////
// Instruction fetch stage
// PC, instruction bus requests and a one-entry buffer
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module core_if_stage import core_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            fetch_enable_i,
  input  logic [XLEN-1:0] boot_addr_i,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  input  logic [XLEN-1:0] instr_rdata_i,
  input  logic            id_ready_i,
  output logic            instr_req_o,
  output logic [XLEN-1:0] instr_addr_o,
  output logic            if_valid_o,
  output if_id_t          if_id_o
);

  logic            fetch_en_q;
  logic            fetch_en;
  logic            outstanding_q;
  logic [XLEN-1:0] pc_q;
  logic            buf_valid_q;
  logic [XLEN-1:0] buf_instr_q;
  logic            buf_free;

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  // Fetch enable is sticky once seen
  assign fetch_en = fetch_enable_i || fetch_en_q;

  // Buffer empty now, or handed to ID this cycle
  assign buf_free = !buf_valid_q || id_ready_i;

  // One request in flight at most
  // Once raised it holds, since the buffer stays empty until rvalid
  assign instr_req_o  = fetch_en && !outstanding_q && buf_free;
  assign instr_addr_o = pc_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fetch_en_q    <= 1'b0;
      outstanding_q <= 1'b0;
      pc_q          <= boot_addr_i;
    end else begin
      if (fetch_enable_i) begin
        fetch_en_q <= 1'b1;
      end
      // Address phase done, wait for response
      if (instr_req_o && instr_gnt_i) begin
        outstanding_q <= 1'b1;
        pc_q          <= pc_q + 32'd4;
      end else if (instr_rvalid_i) begin
        outstanding_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Instruction buffer
  ////////////////////////////////////////////////////////////

  // Fill on response, drain on ID handshake
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      buf_valid_q <= 1'b0;
    end else if (instr_rvalid_i) begin
      buf_valid_q <= 1'b1;
    end else if (buf_valid_q && id_ready_i) begin
      buf_valid_q <= 1'b0;
    end
  end

  // Payload only
  always_ff @(posedge clk_i) begin
    if (instr_rvalid_i) begin
      buf_instr_q <= instr_rdata_i;
    end
  end

  assign if_valid_o    = buf_valid_q;
  assign if_id_o.instr = buf_instr_q;

  // Memory never answers a request that was not granted
  a_rvalid_outstanding: assert property (
    @(posedge clk_i) disable iff (rst_i)
    instr_rvalid_i |-> outstanding_q
  );

endmodule

`default_nettype wire

//--- core_pkg.sv
////////////////////////////////////////////////////////////
// Core package
// Widths, opcodes, ALU operations and stage payloads
////////////////////////////////////////////////////////////

`default_nettype none

package core_pkg;

  // Datapath and register index widths
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  // x0 included, hardwired to zero
  localparam int NUM_REGS   = 32;

  // Major opcodes handled by the decoder
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // funct3 for ALU ops
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_SRL = 3'b101;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // funct3 for stores
  localparam logic [2:0] F3_SB = 3'b000;
  localparam logic [2:0] F3_SW = 3'b010;

  // funct7, base and alternate (SUB)
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // ALU operations
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_PASS_B  // LUI result is the immediate itself
  } alu_op_e;

  // IF to ID, the raw instruction word
  typedef struct packed {
    logic [XLEN-1:0] instr;
  } if_id_t;

  // ID to EX, operands already resolved
  typedef struct packed {
    alu_op_e               alu_op;
    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       op_b;
    logic [XLEN-1:0]       store_data;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rf_we;
    logic                  store;
    logic                  store_byte;
  } id_ex_t;

endpackage

`default_nettype wire

//--- core_register_file.sv
////////////////////////////////////////////////////////////
// Register file
// x1..x31 in flops, x0 reads as zero, 2R/1W
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module core_register_file import core_pkg::*; (
  input  logic clk_i,
  input  logic rst_i,
  rf_if.rf     rf
);

  // No storage for x0
  logic [XLEN-1:0] regs_q [1:NUM_REGS-1];

  // Write port, x0 writes dropped
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (rf.we && (rf.waddr != '0)) begin
      regs_q[rf.waddr] <= rf.wdata;
    end
  end

  // Read ports, zero for x0
  always_comb begin
    rf.rdata_a = (rf.raddr_a == '0) ? '0 : regs_q[rf.raddr_a];
    rf.rdata_b = (rf.raddr_b == '0) ? '0 : regs_q[rf.raddr_b];
  end

endmodule

`default_nettype wire

//--- core_top.sv
////////////////////////////////////////////////////////////
// Core top level
// IF, ID, EX/WB and register file behind plain bus ports
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module core_top import core_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            fetch_enable_i,
  input  logic [XLEN-1:0] boot_addr_i,
  // Instruction bus
  output logic            instr_req_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  output logic [XLEN-1:0] instr_addr_o,
  input  logic [XLEN-1:0] instr_rdata_i,
  // Data bus, stores only
  output logic            data_req_o,
  input  logic            data_gnt_i,
  output logic [XLEN-1:0] data_addr_o,
  output logic [3:0]      data_be_o,
  output logic [XLEN-1:0] data_wdata_o
);

  // Stage handshakes
  logic                  if_valid;
  logic                  id_ready;
  if_id_t                if_id;
  logic                  id_valid;
  logic                  ex_ready;
  id_ex_t                id_ex;

  // Forwarding paths into ID
  logic                  ex_fwd_we;
  logic [REG_ADDR_W-1:0] ex_fwd_rd;
  logic [XLEN-1:0]       ex_fwd_data;
  logic                  wb_fwd_we;
  logic [REG_ADDR_W-1:0] wb_fwd_rd;
  logic [XLEN-1:0]       wb_fwd_data;

  rf_if rf_bus ();

  core_if_stage if_stage_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .fetch_enable_i (fetch_enable_i),
    .boot_addr_i    (boot_addr_i),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .id_ready_i     (id_ready),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .if_valid_o     (if_valid),
    .if_id_o        (if_id)
  );

  core_id_stage id_stage_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .if_valid_i    (if_valid),
    .if_id_i       (if_id),
    .ex_ready_i    (ex_ready),
    .ex_fwd_we_i   (ex_fwd_we),
    .ex_fwd_rd_i   (ex_fwd_rd),
    .ex_fwd_data_i (ex_fwd_data),
    .wb_fwd_we_i   (wb_fwd_we),
    .wb_fwd_rd_i   (wb_fwd_rd),
    .wb_fwd_data_i (wb_fwd_data),
    .rf            (rf_bus),
    .id_ready_o    (id_ready),
    .id_valid_o    (id_valid),
    .id_ex_o       (id_ex)
  );

  core_ex_stage ex_stage_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .id_valid_i    (id_valid),
    .id_ex_i       (id_ex),
    .data_gnt_i    (data_gnt_i),
    .ex_ready_o    (ex_ready),
    .data_req_o    (data_req_o),
    .data_addr_o   (data_addr_o),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o),
    .ex_fwd_we_o   (ex_fwd_we),
    .ex_fwd_rd_o   (ex_fwd_rd),
    .ex_fwd_data_o (ex_fwd_data),
    .wb_fwd_we_o   (wb_fwd_we),
    .wb_fwd_rd_o   (wb_fwd_rd),
    .wb_fwd_data_o (wb_fwd_data),
    .rf            (rf_bus)
  );

  core_register_file register_file_i (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .rf    (rf_bus)
  );

endmodule

`default_nettype wire

//--- rf_if.sv
////////////////////////////////////////////////////////////
// Register file port group
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

interface rf_if import core_pkg::*; ();

  // Read side, two combinational ports
  logic [REG_ADDR_W-1:0] raddr_a;
  logic [REG_ADDR_W-1:0] raddr_b;
  logic [XLEN-1:0]       rdata_a;
  logic [XLEN-1:0]       rdata_b;

  // Write side, one port from WB
  logic                  we;
  logic [REG_ADDR_W-1:0] waddr;
  logic [XLEN-1:0]       wdata;

  // ID stage
  modport reader (output raddr_a, raddr_b, input rdata_a, rdata_b);

  // WB register inside EX
  modport writer (output we, waddr, wdata);

  // Storage itself
  modport rf (
    input  raddr_a, raddr_b, we, waddr, wdata,
    output rdata_a, rdata_b
  );

endinterface

`default_nettype wire

//--- sim.f
core_pkg.sv
rf_if.sv
core_register_file.sv
core_if_stage.sv
core_id_stage.sv
core_ex_stage.sv
core_top.sv
tb_core.sv

//--- tb_core.sv
////////////////////////////////////////////////////////////
// Core testbench
// Directed programs with bus models and a store checker
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_core;

  localparam logic [31:0] BOOT_ADDR     = 32'h0000_0080;
  localparam int          BOOT_WORD     = 32;
  localparam logic [31:0] SENTINEL_ADDR = 32'h0000_07FC;
  localparam int          RESET_CYCLES  = 10;
  localparam int          NUM_TESTS     = 6;
  localparam int          TEST_CYCLES   = 200;

  logic        clk_i;
  logic        rst_i;
  logic        fetch_enable_i;
  logic [31:0] boot_addr_i;
  logic        instr_req_o;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  logic [31:0] instr_addr_o;
  logic [31:0] instr_rdata_i;
  logic        data_req_o;
  logic        data_gnt_i;
  logic [31:0] data_addr_o;
  logic [3:0]  data_be_o;
  logic [31:0] data_wdata_o;

  // Program memory and reference register state
  logic [31:0] imem [0:255];
  logic [31:0] ref_regs [0:31];
  int          prog_idx;
  int          seed = 26230;
  bit          gnt_random;

  // Pending instruction response
  bit          resp_active;
  int          resp_delay;
  logic [31:0] resp_addr;

  // Fetch granted at the last rising edge
  bit          fetch_granted;
  logic [31:0] granted_addr;

  // Expected and observed stores, and fetch addresses
  logic [31:0] exp_addr [$];
  logic [31:0] exp_be [$];
  logic [31:0] exp_data [$];
  logic [31:0] got_addr [$];
  logic [31:0] got_be [$];
  logic [31:0] got_data [$];
  logic [31:0] fetch_log [$];

  core_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      fail_now($sformatf("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Bus models
  ////////////////////////////////////////////////////////////

  // Grants and responses change on the falling edge only
  always @(negedge clk_i) begin
    instr_gnt_i = (($random(seed) & 3) != 0);
    data_gnt_i  = gnt_random ? (($random(seed) & 3) == 0) : 1'b1;
    if (rst_i) begin
      resp_active    = 1'b0;
      instr_rvalid_i = 1'b0;
    end else begin
      // Response starts the cycle after its grant
      if (fetch_granted) begin
        resp_active = 1'b1;
        resp_addr   = granted_addr;
        resp_delay  = $random(seed) & 3;
      end
      if (resp_active && resp_delay == 0) begin
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = imem[resp_addr[9:2]];
        resp_active    = 1'b0;
      end else begin
        instr_rvalid_i = 1'b0;
        if (resp_active) begin
          resp_delay--;
        end
      end
    end
  end

  // Handshakes as seen by the DUT at the rising edge
  always @(posedge clk_i) begin
    fetch_granted = !rst_i && instr_req_o && instr_gnt_i;
    if (fetch_granted) begin
      granted_addr = instr_addr_o;
      fetch_log.push_back(instr_addr_o);
    end
    if (!rst_i && data_req_o && data_gnt_i) begin
      got_addr.push_back(data_addr_o);
      got_be.push_back({28'h0, data_be_o});
      got_data.push_back(data_wdata_o);
    end
  end

  ////////////////////////////////////////////////////////////
  // Program builder with ISA reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[8'(BOOT_WORD + prog_idx)] = word;
    prog_idx++;
  endtask

  task automatic set_ref(input logic [4:0] rd, input logic [31:0] val);
    if (rd != 5'd0) begin
      ref_regs[rd] = val;
    end
  endtask

  task automatic emit_rr(input logic [2:0] f3, input bit alt, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    a = ref_regs[rs1];
    b = ref_regs[rs2];
    case (f3)
      3'b000:  r = alt ? a - b : a + b;
      3'b001:  r = a << b[4:0];
      3'b100:  r = a ^ b;
      3'b101:  r = a >> b[4:0];
      3'b110:  r = a | b;
      default: r = a & b;
    endcase
    emit({alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h33});
    set_ref(rd, r);
  endtask

  task automatic emit_imm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [11:0] imm);
    logic [31:0] a;
    logic [31:0] r;
    a = ref_regs[rs1];
    case (f3)
      3'b000:  r = a + sext12(imm);
      3'b100:  r = a ^ sext12(imm);
      3'b110:  r = a | sext12(imm);
      default: r = a & sext12(imm);
    endcase
    emit({imm, rs1, f3, rd, 7'h13});
    set_ref(rd, r);
  endtask

  task automatic emit_lui(input logic [4:0] rd, input logic [19:0] imm);
    emit({imm, rd, 7'h37});
    set_ref(rd, {imm, 12'h000});
  endtask

  // Expected bus beat follows the SW and SB lane rules
  task automatic emit_store(input bit is_byte, input logic [4:0] rs2, input logic [4:0] rs1,
                            input logic [11:0] imm);
    logic [31:0] addr;
    addr = ref_regs[rs1] + sext12(imm);
    emit({imm[11:5], rs2, rs1, is_byte ? 3'b000 : 3'b010, imm[4:0], 7'h23});
    exp_addr.push_back({addr[31:2], 2'b00});
    exp_be.push_back(is_byte ? {28'h0, 4'b0001 << addr[1:0]} : 32'h0000_000F);
    exp_data.push_back(is_byte ? {4{ref_regs[rs2][7:0]}} : ref_regs[rs2]);
  endtask

  task automatic new_program;
    for (int i = 0; i < 256; i++) begin
      // Unsupported opcode, low bits of the word index above it
      imem[8'(i)] = {25'(i), 7'h7F};
    end
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = 32'h0;
    end
    prog_idx = 0;
    exp_addr.delete();
    exp_be.delete();
    exp_data.delete();
  endtask

  ////////////////////////////////////////////////////////////
  // Run one program from reset and compare its stores
  ////////////////////////////////////////////////////////////

  task automatic run_program(input int enable_delay);
    // Last store marks the end of the program
    emit_store(1'b0, 5'd0, 5'd0, SENTINEL_ADDR[11:0]);
    @(negedge clk_i);
    rst_i          = 1'b1;
    fetch_enable_i = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_i = 1'b0;
    got_addr.delete();
    got_be.delete();
    got_data.delete();
    fetch_log.delete();
    // No fetch may start while disabled
    repeat (enable_delay) begin
      @(negedge clk_i);
      assert (!instr_req_o && fetch_log.size() == 0) else begin
        fail_now("Instruction request raised before fetch enable");
      end
    end
    fetch_enable_i = 1'b1;
    while (!(got_addr.size() > 0 && got_addr[$] == SENTINEL_ADDR)) begin
      @(negedge clk_i);
    end
    check_val("instr_addr_o", fetch_log[0], BOOT_ADDR);
    for (int i = 1; i < fetch_log.size(); i++) begin
      check_val("instr_addr_o", fetch_log[i], fetch_log[i-1] + 32'd4);
    end
    check_val("store_count", 32'(got_addr.size()), 32'(exp_addr.size()));
    for (int i = 0; i < exp_addr.size(); i++) begin
      check_val("data_addr_o", got_addr[i], exp_addr[i]);
      check_val("data_be_o", got_be[i], exp_be[i]);
      check_val("data_wdata_o", got_data[i], exp_data[i]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_boot_fetch;
    new_program();
    emit_imm(3'b000, 5'd1, 5'd0, 12'd5);
    emit_store(1'b0, 5'd1, 5'd0, 12'h100);
    run_program(5);
  endtask

  task automatic test_imm_lui;
    new_program();
    emit_lui(5'd2, 20'h12345);
    emit_imm(3'b000, 5'd2, 5'd2, 12'h678);
    emit_imm(3'b100, 5'd3, 5'd2, 12'hFFF);
    emit_imm(3'b110, 5'd4, 5'd0, 12'h0F0);
    emit_imm(3'b111, 5'd5, 5'd3, 12'h7FF);
    emit_imm(3'b000, 5'd6, 5'd4, 12'h800);
    emit_store(1'b0, 5'd2, 5'd0, 12'h200);
    emit_store(1'b0, 5'd3, 5'd0, 12'h204);
    emit_store(1'b0, 5'd4, 5'd0, 12'h208);
    emit_store(1'b0, 5'd5, 5'd4, 12'h118);
    emit_store(1'b0, 5'd6, 5'd0, 12'h210);
    run_program(0);
  endtask

  // Every op reads the result of the one before it
  task automatic test_rr_forwarding;
    new_program();
    emit_imm(3'b000, 5'd1, 5'd0, 12'd7);
    emit_imm(3'b000, 5'd2, 5'd0, 12'd3);
    emit_rr(3'b000, 1'b1, 5'd3, 5'd1, 5'd2);
    emit_rr(3'b001, 1'b0, 5'd4, 5'd3, 5'd2);
    emit_rr(3'b101, 1'b0, 5'd5, 5'd4, 5'd1);
    emit_rr(3'b000, 1'b0, 5'd6, 5'd5, 5'd4);
    emit_rr(3'b111, 1'b0, 5'd7, 5'd6, 5'd4);
    emit_rr(3'b110, 1'b0, 5'd8, 5'd7, 5'd1);
    emit_rr(3'b100, 1'b0, 5'd9, 5'd8, 5'd6);
    emit_rr(3'b000, 1'b1, 5'd10, 5'd2, 5'd9);
    emit_rr(3'b101, 1'b0, 5'd11, 5'd10, 5'd2);
    emit_store(1'b0, 5'd11, 5'd0, 12'h300);
    emit_store(1'b0, 5'd10, 5'd0, 12'h304);
    emit_store(1'b0, 5'd9, 5'd0, 12'h308);
    emit_store(1'b0, 5'd3, 5'd0, 12'h30C);
    run_program(0);
  endtask

  task automatic test_byte_store_x0;
    new_program();
    emit_lui(5'd1, 20'hABCDE);
    emit_imm(3'b000, 5'd1, 5'd1, 12'h1A7);
    emit_imm(3'b000, 5'd2, 5'd0, 12'h400);
    emit_store(1'b1, 5'd1, 5'd2, 12'h001);
    emit_store(1'b1, 5'd2, 5'd2, 12'h002);
    emit_store(1'b1, 5'd1, 5'd2, 12'h003);
    emit_store(1'b1, 5'd1, 5'd2, 12'h000);
    emit_imm(3'b000, 5'd0, 5'd0, 12'd55);
    emit_rr(3'b000, 1'b0, 5'd0, 5'd1, 5'd1);
    emit_store(1'b0, 5'd0, 5'd2, 12'h010);
    run_program(0);
  endtask

  task automatic test_random_data_grant;
    new_program();
    gnt_random = 1'b1;
    for (int i = 0; i < 8; i++) begin
      emit_imm(3'b000, 5'd1, 5'd1, 12'd17);
      emit_store(i[0], 5'd1, 5'd0, 12'(12'h500 + 5 * i));
    end
    run_program(0);
    gnt_random = 1'b0;
  endtask

  task automatic test_unsupported_opcode;
    new_program();
    emit_imm(3'b000, 5'd5, 5'd0, 12'h055);
    // Custom opcode naming x5 as destination
    emit({20'h1F0F0, 5'd5, 7'h0B});
    // Shift by immediate is outside the supported set
    emit({12'h004, 5'd5, 3'b001, 5'd5, 7'h13});
    emit_store(1'b0, 5'd5, 5'd0, 12'h600);
    run_program(0);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    rst_i          = 1'b1;
    fetch_enable_i = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = 32'h0;
    data_gnt_i     = 1'b0;
    gnt_random     = 1'b0;
    resp_active    = 1'b0;
    resp_delay     = 0;
    resp_addr      = 32'h0;
    test_boot_fetch();
    test_imm_lui();
    test_rr_forwarding();
    test_byte_store_x0();
    test_random_data_grant();
    test_unsupported_opcode();
    $display("Test passed");
    $finish;
  end

  // Budget covers each test plus its reset
  initial begin
    repeat (NUM_TESTS * (TEST_CYCLES + RESET_CYCLES)) @(posedge clk_i);
    fail_now("Watchdog expired before all tests completed");
  end

endmodule

`default_nettype wire
